// File: Makefile
VERILATOR ?= verilator
TOP       := board_ctrl_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/board_ctrl_top.sv
`include "board_defines.svh"

module board_ctrl_top #(
    parameter int unsigned TICK_WIDTH     = `BOARD_TICK_WIDTH,
    parameter int unsigned MV_DELAY_TICKS = `BOARD_MV_DELAY_TICKS
) (
    input  logic                         sysclk,
    input  logic                         rst_n,
    // host register bus
    input  board_pkg::reg_addr_t         reg_raddr,
    input  board_pkg::reg_addr_t         reg_waddr,
    input  board_pkg::reg_data_t         reg_wdata,
    input  logic                         reg_wen,
    output board_pkg::reg_data_t         reg_rdata,
    // per-axis inputs
    input  board_pkg::axis_vec_t         dout,
    input  board_pkg::axis_vec_t         enc_a,
    input  board_pkg::axis_vec_t         enc_b,
    input  board_pkg::axis_vec_t         enc_i,
    input  board_pkg::axis_vec_t         neg_limit,
    input  board_pkg::axis_vec_t         pos_limit,
    input  board_pkg::axis_vec_t         home,
    input  board_pkg::axis_vec_t         fault,
    input  board_pkg::axis_vec_t         safety_amp_disable,
    // board level inputs
    input  logic                         dout_cfg_valid,
    input  logic                         dout_cfg_bidir,
    input  logic                         relay,
    input  logic                         mv_faultn,
    input  logic                         mv_good,
    input  logic                         v_fault,
    input  logic                         io1_8,
    input  logic [`BOARD_ID_W-1:0]       board_id,
    input  logic [`BOARD_TEMP_W-1:0]     temp_sense,
    // control outputs
    output board_pkg::axis_vec_t         amp_disable,
    output logic                         reboot,
    output logic                         dout_cfg_reset,
    output logic                         pwr_enable,
    output logic                         relay_on,
    output logic                         eth1394,
    output logic                         pwr_enable_cmd,
    output board_pkg::axis_vec_t         amp_enable_cmd,
    output board_pkg::reg_data_t         reg_debug
);
    import board_pkg::*;

    logic         tick;           // slow enable, shared by both timers
    logic         wdog_timeout;
    logic         amp_hold;       // supply settling hold
    logic         powerup_cmd;
    wdog_period_t wdog_period;

    // --------------------
    // slow tick and timers
    // --------------------
    tick_gen #(.WIDTH(TICK_WIDTH)) u_tick_gen (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .tick   (tick)
    );

    host_watchdog u_host_watchdog (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .tick         (tick),
        .reg_wen      (reg_wen),
        .powerup_cmd  (powerup_cmd),
        .wdog_period  (wdog_period),
        .wdog_timeout (wdog_timeout)
    );

    motor_power_delay #(.DELAY_TICKS(MV_DELAY_TICKS)) u_motor_power_delay (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .tick     (tick),
        .mv_good  (mv_good),
        .amp_hold (amp_hold)
    );

    // register file, every port name matches a top port or wire
    board_regs u_board_regs (.*);

endmodule

// File: logic/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// --------------------
// bus and word widths
// --------------------
`define BOARD_ADDR_W            16      // host register address
`define BOARD_DATA_W            32      // host register word
`define BOARD_WDOG_W            16      // watchdog period/count
`define BOARD_ID_W              4       // rotary switch
`define BOARD_TEMP_W            16      // temperature sensor reading

// number of motor axes on the card
`define BOARD_NUM_AXES          4

// address bits 15:12 selecting the main register block
`define BOARD_ADDR_SPACE_MAIN   4'h0

// --------------------
// identification words
// --------------------
`define BOARD_VERSION           32'h514C4131    // board id word
`define BOARD_FW_VERSION        32'd7           // firmware revision

// --------------------
// reset values
// --------------------
// 0x1680 ticks, about 30 ms at the default tick rate
`define BOARD_WDOG_PERIOD_RESET 16'h1680
`define BOARD_DEBUG_RESET       32'h2000

// --------------------
// slow tick and delays
// --------------------
`define BOARD_TICK_WIDTH        8       // tick every 2^8 sysclk cycles
// about 40 ms of amp hold after motor voltage good
`define BOARD_MV_DELAY_TICKS    7680

`endif

// File: logic/board_pkg.sv
`include "board_defines.svh"

package board_pkg;

    // --------------------
    // host bus words
    // --------------------
    typedef logic [`BOARD_ADDR_W-1:0] reg_addr_t;     // full host address
    typedef logic [`BOARD_DATA_W-1:0] reg_data_t;     // one register word

    // one bit per axis, bit 0 is axis 1
    typedef logic [`BOARD_NUM_AXES-1:0] axis_vec_t;

    // watchdog period, counted in slow ticks
    typedef logic [`BOARD_WDOG_W-1:0] wdog_period_t;

    // --------------------
    // register offsets
    // --------------------
    // address bits 3:0 inside the main space
    typedef enum logic [3:0] {
        REG_STATUS   = 4'd0,    // board status, masked control writes
        REG_PHYCTRL  = 4'd1,    // phy request word
        REG_PHYDATA  = 4'd2,    // phy transfer data
        REG_TIMEOUT  = 4'd3,    // watchdog period
        REG_VERSION  = 4'd4,    // board id word
        REG_TEMPSNS  = 4'd5,    // temperature sensor
        REG_DIGIOUT  = 4'd6,    // digital outputs
        REG_FVERSION = 4'd7,    // firmware revision
        REG_DIGIN    = 4'd11,   // digital inputs, packed
        REG_DEBUG    = 4'd15    // scratch for debug
    } reg_offset_e;

endpackage

// File: logic/board_regs.sv
`include "board_defines.svh"

module board_regs (
    input  logic                         sysclk,
    input  logic                         rst_n,
    // host register bus
    input  board_pkg::reg_addr_t         reg_raddr,
    input  board_pkg::reg_addr_t         reg_waddr,
    input  board_pkg::reg_data_t         reg_wdata,
    input  logic                         reg_wen,
    output board_pkg::reg_data_t         reg_rdata,     // valid one cycle after raddr
    // per-axis inputs
    input  board_pkg::axis_vec_t         dout,
    input  board_pkg::axis_vec_t         enc_a,
    input  board_pkg::axis_vec_t         enc_b,
    input  board_pkg::axis_vec_t         enc_i,
    input  board_pkg::axis_vec_t         neg_limit,
    input  board_pkg::axis_vec_t         pos_limit,
    input  board_pkg::axis_vec_t         home,
    input  board_pkg::axis_vec_t         fault,
    input  board_pkg::axis_vec_t         safety_amp_disable,
    // board level inputs
    input  logic                         dout_cfg_valid,
    input  logic                         dout_cfg_bidir,
    input  logic                         relay,         // safety relay state
    input  logic                         mv_faultn,     // motor supply fault, active low
    input  logic                         mv_good,
    input  logic                         v_fault,       // encoder supply fault
    input  logic                         io1_8,
    input  logic [`BOARD_ID_W-1:0]       board_id,
    input  logic [`BOARD_TEMP_W-1:0]     temp_sense,
    // from watchdog and power-up delay
    input  logic                         wdog_timeout,
    input  logic                         amp_hold,
    // control outputs
    output board_pkg::axis_vec_t         amp_disable,
    output logic                         reboot,
    output logic                         dout_cfg_reset,
    output logic                         pwr_enable,
    output logic                         relay_on,
    output logic                         eth1394,
    output logic                         pwr_enable_cmd,
    output board_pkg::axis_vec_t         amp_enable_cmd,
    output logic                         powerup_cmd,
    output board_pkg::wdog_period_t      wdog_period,
    output board_pkg::reg_data_t         reg_debug
);
    import board_pkg::*;

    axis_vec_t        reg_disable;     // sticky per-axis disable
    logic [15:0]      phy_ctrl;        // phy request bitstream
    logic [15:0]      phy_data;        // phy register data
    reg_data_t        reg_status;
    reg_data_t        reg_digin;
    logic             write_main;      // accepted write into this block
    logic             write_status;
    reg_offset_e      waddr_off;
    reg_offset_e      raddr_off;
    axis_vec_t        axis_mask;       // status write, axis mask bits
    axis_vec_t        axis_val;        // status write, axis enable bits

    // --------------------
    // write decode
    // --------------------
    assign waddr_off    = reg_offset_e'(reg_waddr[3:0]);
    assign raddr_off    = reg_offset_e'(reg_raddr[3:0]);
    assign write_main   = reg_wen && (reg_waddr[15:12] == `BOARD_ADDR_SPACE_MAIN)
                          && (reg_waddr[7:4] == 4'd0);
    assign write_status = write_main && (waddr_off == REG_STATUS);

    assign axis_mask = reg_wdata[11:8];    // 15:12 unused on a 4-axis card
    assign axis_val  = reg_wdata[3:0];

    // host trying to power up, used to clear error flags
    assign pwr_enable_cmd = write_status & reg_wdata[19] & reg_wdata[18];
    assign amp_enable_cmd = write_status ? (axis_mask & axis_val) : '0;
    assign powerup_cmd    = pwr_enable_cmd | (|amp_enable_cmd);

    // hold from supply settling overrides the latch
    assign amp_disable = reg_disable | {`BOARD_NUM_AXES{amp_hold}};

    // --------------------
    // packed read words
    // --------------------
    assign reg_status = {
        4'(`BOARD_NUM_AXES), board_id,                          // byte 3
        wdog_timeout, eth1394, dout_cfg_valid, dout_cfg_bidir,
        mv_good, pwr_enable, ~relay, relay_on,                  // byte 2
        ~mv_faultn, 3'd0, fault,                                // byte 1
        safety_amp_disable, ~reg_disable                        // byte 0, 1 = amp enabled
    };

    assign reg_digin = {v_fault, io1_8, 2'd0, enc_a, enc_b, enc_i, dout,
                        neg_limit, pos_limit, home};

    // --------------------
    // control registers
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            reg_disable    <= '1;      // all amps off
            pwr_enable     <= 1'b0;
            relay_on       <= 1'b0;
            eth1394        <= 1'b0;
            reboot         <= 1'b0;
            dout_cfg_reset <= 1'b0;
            wdog_period    <= `BOARD_WDOG_PERIOD_RESET;
            reg_debug      <= `BOARD_DEBUG_RESET;
        end else begin
            reboot <= 1'b0;            // pulse unless set below
            if (write_status) begin
                // mask bit picks value bit, else keep; no amps without power
                reg_disable <= {`BOARD_NUM_AXES{~pwr_enable}}
                               | (axis_mask & ~axis_val)
                               | (~axis_mask & reg_disable);
                relay_on       <= reg_wdata[17] ? reg_wdata[16] : relay_on;
                pwr_enable     <= reg_wdata[19] ? reg_wdata[18] : pwr_enable;
                reboot         <= reg_wdata[21] & reg_wdata[20];
                eth1394        <= reg_wdata[23] ? reg_wdata[22] : eth1394;
                dout_cfg_reset <= reg_wdata[24];    // no mask for this one
            end else begin
                // watchdog kills every axis, safety input only its own
                reg_disable <= reg_disable | (wdog_timeout ? '1 : safety_amp_disable);
            end
            if (!write_main) begin
                dout_cfg_reset <= 1'b0;
            end
            if (write_main) begin
                case (waddr_off)
                    REG_TIMEOUT: wdog_period <= reg_wdata[`BOARD_WDOG_W-1:0];
                    REG_DEBUG:   reg_debug   <= reg_wdata;
                    default:     ;
                endcase
            end
        end
    end

    // scratch phy registers
    always_ff @(posedge sysclk) begin
        if (write_main) begin
            case (waddr_off)
                REG_PHYCTRL: phy_ctrl <= reg_wdata[15:0];
                REG_PHYDATA: phy_data <= reg_wdata[15:0];
                default:     ;
            endcase
        end
    end

    // --------------------
    // read mux
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!write_main) begin     // write wins, rdata holds
            case (raddr_off)
                REG_STATUS:   reg_rdata <= reg_status;
                REG_PHYCTRL:  reg_rdata <= {16'd0, phy_ctrl};
                REG_PHYDATA:  reg_rdata <= {16'd0, phy_data};
                REG_TIMEOUT:  reg_rdata <= reg_data_t'(wdog_period);
                REG_VERSION:  reg_rdata <= `BOARD_VERSION;
                REG_TEMPSNS:  reg_rdata <= reg_data_t'(temp_sense);
                REG_DIGIOUT:  reg_rdata <= reg_data_t'(dout);
                REG_FVERSION: reg_rdata <= `BOARD_FW_VERSION;
                REG_DIGIN:    reg_rdata <= reg_digin;
                REG_DEBUG:    reg_rdata <= reg_debug;
                default:      reg_rdata <= '0;  // unused offsets
            endcase
        end
    end

endmodule

// File: logic/host_watchdog.sv
module host_watchdog (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    tick,           // slow enable from prescaler
    input  logic                    reg_wen,        // any host write
    input  logic                    powerup_cmd,    // host asks for power/amps
    input  board_pkg::wdog_period_t wdog_period,    // 0 stops the watchdog
    output logic                    wdog_timeout    // sticky until powerup_cmd
);
    import board_pkg::*;

    wdog_period_t wdog_count;   // ticks since last host write
    logic         wdog_active;  // period set, watchdog armed

    assign wdog_active = (wdog_period != '0);

    // --------------------
    // counter and flag
    // --------------------
    // priority: power-up command, then host write, then tick
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            wdog_count   <= '0;
            wdog_timeout <= 1'b0;
        end else if (powerup_cmd) begin
            wdog_count   <= '0;         // restart timing
            wdog_timeout <= 1'b0;       // host re-enabling, drop flag
        end else if (reg_wen) begin
            wdog_count   <= '0;         // host still alive
        end else if (tick && wdog_active) begin
            if (wdog_count < wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                // reached the period with no write in between
                wdog_timeout <= 1'b1;
            end
        end
    end

endmodule

// File: logic/motor_power_delay.sv
`include "board_defines.svh"

module motor_power_delay #(
    parameter int unsigned DELAY_TICKS = `BOARD_MV_DELAY_TICKS    // hold time in ticks
) (
    input  logic sysclk,
    input  logic rst_n,
    input  logic tick,      // slow enable from prescaler
    input  logic mv_good,   // motor supply in range
    output logic amp_hold   // keep amps off while supply settles
);

    localparam int unsigned CNT_W = $clog2(DELAY_TICKS + 1);
    localparam logic [CNT_W-1:0] DELAY_LAST = CNT_W'(DELAY_TICKS);

    logic [CNT_W-1:0] delay_count;  // ticks since mv_good rose
    logic             hold_q;       // registered hold

    // --------------------
    // settle timer
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            delay_count <= '0;
            hold_q      <= 1'b1;        // amps held off out of reset
        end else if (!mv_good) begin
            delay_count <= '0;          // supply lost, start over
            hold_q      <= 1'b1;
        end else if (tick) begin
            if (delay_count < DELAY_LAST) begin
                delay_count <= delay_count + 1'b1;
                hold_q      <= 1'b1;    // still settling
            end else begin
                hold_q      <= 1'b0;    // delay done, release
            end
        end
    end

    // low supply holds the amps at once, not one cycle late
    assign amp_hold = hold_q | ~mv_good;

endmodule

// File: logic/tick_gen.sv
`include "board_defines.svh"

module tick_gen #(
    parameter int unsigned WIDTH = `BOARD_TICK_WIDTH  // log2 of tick period
) (
    input  logic sysclk,
    input  logic rst_n,
    output logic tick       // one-cycle enable, not a clock
);

    logic [WIDTH-1:0] count;    // free-running prescaler

    // tick goes high in the cycle after the counter is all ones,
    // so the period is exactly 2^WIDTH sysclk cycles
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            count <= count + 1'b1;      // wraps naturally
            tick  <= &count;            // pulse on wrap
        end
    end

endmodule

// File: tb.f
+incdir+logic
logic/board_pkg.sv
logic/tick_gen.sv
logic/host_watchdog.sv
logic/motor_power_delay.sv
logic/board_regs.sv
logic/board_ctrl_top.sv
tests/board_ctrl_props.sv
tests/board_ctrl_tb.sv

// File: tests/board_ctrl_props.sv
module board_ctrl_props (
    input logic                 sysclk,
    input logic                 rst_n,
    input logic                 reboot,
    input logic                 mv_good,
    input logic                 pwr_enable,
    input logic                 relay_on,
    input board_pkg::axis_vec_t amp_disable
);

    // --------------------
    // control pulses
    // --------------------
    // reboot request is a single-cycle pulse
    reboot_single: assert property (
        @(posedge sysclk) disable iff (!rst_n) reboot |=> !reboot
    ) else $error("reboot held high for two cycles");

    // --------------------
    // motor supply
    // --------------------
    // no amp may run without motor voltage
    amp_off_no_mv: assert property (
        @(posedge sysclk) disable iff (!rst_n) !mv_good |-> (amp_disable == '1)
    ) else $error("amp enabled while mv_good low");

    // board comes out of reset unpowered
    off_after_reset: assert property (
        @(posedge sysclk) $rose(rst_n) |-> (!pwr_enable && !relay_on)
    ) else $error("power or relay on right after reset");

endmodule

// File: tests/board_ctrl_tb.sv
`include "board_defines.svh"

module board_ctrl_tb;
    import board_pkg::*;

    localparam int TICK_WIDTH     = 2;
    localparam int MV_DELAY_TICKS = 8;
    localparam int TICK_PERIOD    = 1 << TICK_WIDTH;
    localparam int WAIT_LIMIT     = 200;     // cycles per bounded wait

    // status write fields, mask bit above value bit
    localparam reg_data_t PWR_ON    = 32'h000C_0000;
    localparam reg_data_t PWR_OFF   = 32'h0008_0000;
    localparam reg_data_t RELAY_ON  = 32'h0003_0000;
    localparam reg_data_t ETH_ON    = 32'h00C0_0000;
    localparam reg_data_t REBOOT    = 32'h0030_0000;
    localparam reg_data_t CFG_RESET = 32'h0100_0000;    // no mask bit
    localparam reg_data_t ALL_MASKS = 32'h00AA_0F00;

    logic sysclk = 1'b0;
    logic rst_n;
    reg_addr_t reg_raddr, reg_waddr;
    reg_data_t reg_wdata, reg_rdata, reg_debug;
    logic reg_wen;
    axis_vec_t dout, enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault;
    axis_vec_t safety_amp_disable, amp_disable, amp_enable_cmd;
    logic dout_cfg_valid, dout_cfg_bidir, relay, mv_faultn, mv_good, v_fault, io1_8;
    logic [3:0] board_id;
    logic [15:0] temp_sense;
    logic reboot, dout_cfg_reset, pwr_enable, relay_on, eth1394, pwr_enable_cmd;

    // expected board state
    logic m_pwr, m_relay_on, m_eth, m_timeout;
    axis_vec_t m_enabled;               // 1 = amp enabled
    logic seen_pwr_cmd;                 // cmd outputs caught mid write
    axis_vec_t seen_amp_cmd;
    logic [15:0] lfsr_state;
    int error_count = 0;

    board_ctrl_top #(.TICK_WIDTH(TICK_WIDTH), .MV_DELAY_TICKS(MV_DELAY_TICKS)) dut (.*);

    bind board_ctrl_top board_ctrl_props props (
        .sysclk(sysclk), .rst_n(rst_n), .reboot(reboot), .mv_good(mv_good),
        .pwr_enable(pwr_enable), .relay_on(relay_on), .amp_disable(amp_disable)
    );

    always #5 sysclk = ~sysclk;

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // galois step, taps 16 14 13 11
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic reg_addr_t main_addr(input reg_offset_e off);
        return {`BOARD_ADDR_SPACE_MAIN, 8'h00, off};
    endfunction

    function automatic reg_data_t axis_word(input axis_vec_t mask, input axis_vec_t val);
        return {20'd0, mask, 4'd0, val};
    endfunction

    function automatic reg_data_t expect_status();
        return {4'(`BOARD_NUM_AXES), board_id, m_timeout, m_eth, dout_cfg_valid,
                dout_cfg_bidir, mv_good, m_pwr, ~relay, m_relay_on, ~mv_faultn, 3'b000,
                fault, safety_amp_disable, m_enabled};
    endfunction

    task automatic report_failure();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
            report_failure();
        end
    endtask

    task automatic check_axes(input axis_vec_t got, input axis_vec_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b", $time, what, exp, got);
            report_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b", $time, what, exp, got);
            report_failure();
        end
    endtask

    // --------------------
    // bus access
    // --------------------
    // all tasks start and end 1 unit after a rising edge
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        #4;                                 // mid cycle, combinational cmds settled
        seen_pwr_cmd = pwr_enable_cmd;
        seen_amp_cmd = amp_enable_cmd;
        @(posedge sysclk);
        #1 reg_wen = 1'b0;
    endtask

    task automatic read_reg(input reg_offset_e off, output reg_data_t data);
        reg_raddr = main_addr(off);
        @(posedge sysclk);
        #1 data = reg_rdata;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge sysclk);
        #1;
    endtask

    // masked status write, expected state follows the register rules
    task automatic status_write(input reg_data_t data);
        logic pwr_old;
        logic pwr_cmd;
        axis_vec_t mask, val, amp_cmd;
        pwr_old = m_pwr;
        mask    = data[11:8];
        val     = data[3:0];
        pwr_cmd = data[19] & data[18];
        amp_cmd = mask & val;
        if (data[19]) m_pwr = data[18];
        if (data[17]) m_relay_on = data[16];
        if (data[23]) m_eth = data[22];
        m_enabled = pwr_old ? ((m_enabled & ~mask) | (mask & val)) : '0;
        if (pwr_cmd || amp_cmd != '0) m_timeout = 1'b0;
        write_reg(main_addr(REG_STATUS), data);
        check_bit(seen_pwr_cmd, pwr_cmd, "pwr_enable_cmd");
        check_axes(seen_amp_cmd, amp_cmd, "amp_enable_cmd");
    endtask

    task automatic check_status(input string what);
        reg_data_t d;
        read_reg(REG_STATUS, d);
        check_word(d, expect_status(), what);
    endtask

    task automatic wait_amp_disable(input axis_vec_t exp, input string what);
        int n;
        n = 0;
        while (amp_disable !== exp && n < WAIT_LIMIT) begin
            idle(1);
            n++;
        end
        if (amp_disable !== exp) begin
            $display("timeout at %0t: amp_disable never reached %b (%s)", $time, exp, what);
            report_failure();
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_reset_values();
        reg_data_t d;
        read_reg(REG_TIMEOUT, d);
        check_word(d, reg_data_t'(`BOARD_WDOG_PERIOD_RESET), "timeout reset");
        read_reg(REG_DEBUG, d);
        check_word(d, `BOARD_DEBUG_RESET, "debug reset");
        read_reg(REG_VERSION, d);
        check_word(d, `BOARD_VERSION, "version");
        read_reg(REG_FVERSION, d);
        check_word(d, `BOARD_FW_VERSION, "firmware version");
        read_reg(reg_offset_e'(4'd9), d);
        check_word(d, '0, "unused offset");
        check_axes(amp_disable, '1, "amp_disable after reset");
        check_bit(reboot | dout_cfg_reset | eth1394, 1'b0, "pulses and eth after reset");
        check_status("status after reset");
    endtask

    task automatic test_masked_writes();
        axis_vec_t m, v;
        status_write(random_bits(32) & ~(ALL_MASKS | CFG_RESET));  // no field selected
        check_status("status, unmasked write");
        status_write(PWR_ON | RELAY_ON | ETH_ON);
        check_bit(pwr_enable, 1'b1, "pwr_enable");
        check_bit(relay_on, 1'b1, "relay_on");
        check_bit(eth1394, 1'b1, "eth1394");
        status_write(PWR_OFF);
        status_write(axis_word('1, '1));    // ignored, no power
        check_status("axes without power");
        status_write(PWR_ON);
        status_write(axis_word('1, axis_vec_t'(random_bits(4))));
        check_status("axes with power");
        m = axis_vec_t'(random_bits(4));
        v = axis_vec_t'(random_bits(4));
        status_write(axis_word(m, v));
        check_status("partial axis mask");
        status_write(REBOOT | CFG_RESET);
        check_bit(reboot, 1'b1, "reboot pulse");
        check_bit(dout_cfg_reset, 1'b1, "dout_cfg_reset pulse");
        idle(1);
        check_bit(reboot, 1'b0, "reboot end");
        check_bit(dout_cfg_reset, 1'b0, "dout_cfg_reset end");
        status_write(PWR_OFF | 32'h0002_0000 | 32'h0080_0000);  // relay, eth off too
        status_write('0);                                       // drops every axis
        check_status("power off");
    endtask

    task automatic test_read_words();
        reg_data_t d, w;
        {dout, enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault} = random_bits(32);
        {dout_cfg_valid, dout_cfg_bidir, relay, mv_faultn, v_fault, io1_8} = 6'(random_bits(6));
        safety_amp_disable = axis_vec_t'(random_bits(4));
        board_id   = 4'(random_bits(4));
        temp_sense = 16'(random_bits(16));
        idle(1);
        check_status("status word");
        read_reg(REG_DIGIN, d);
        check_word(d, {v_fault, io1_8, 2'b00, enc_a, enc_b, enc_i, dout, neg_limit,
                       pos_limit, home}, "digin word");
        read_reg(REG_TEMPSNS, d);
        check_word(d, {16'd0, temp_sense}, "temp_sense");
        read_reg(REG_DIGIOUT, d);
        check_word(d, {28'd0, dout}, "dout");
        safety_amp_disable = '0;
        w = {16'd0, 16'(random_bits(16))};
        write_reg(main_addr(REG_PHYCTRL), w);
        read_reg(REG_PHYCTRL, d);
        check_word(d, w, "phy_ctrl");
        w = {16'd0, 16'(random_bits(16))};
        write_reg(main_addr(REG_PHYDATA), w);
        read_reg(REG_PHYDATA, d);
        check_word(d, w, "phy_data");
        w = random_bits(32);
        write_reg(main_addr(REG_DEBUG), w);
        read_reg(REG_VERSION, d);
        check_word(d, `BOARD_VERSION, "version before write");
        reg_raddr = main_addr(REG_TIMEOUT);     // a read here would change rdata
        write_reg(main_addr(REG_DEBUG), w);     // rdata holds during write
        check_word(reg_rdata, `BOARD_VERSION, "rdata during write");
        // other space, then nonzero bits 7:4
        write_reg({4'h1, 8'h00, REG_DEBUG}, ~w);
        write_reg({4'h0, 4'h0, 4'h2, REG_DEBUG}, ~w);
        write_reg({4'h0, 4'h0, 4'h3, REG_STATUS}, PWR_ON);
        read_reg(REG_DEBUG, d);
        check_word(d, w, "debug after foreign writes");
        check_word(reg_debug, w, "reg_debug port");
        check_bit(pwr_enable, 1'b0, "pwr_enable after foreign write");
    endtask

    task automatic test_watchdog();
        reg_data_t d;
        int n;
        status_write(PWR_ON);
        status_write(axis_word('1, '1));
        wait_amp_disable('0, "amps on before watchdog");
        write_reg(main_addr(REG_TIMEOUT), 32'd3);
        n = 0;
        d = '0;
        while (!d[23] && n < WAIT_LIMIT) begin
            read_reg(REG_STATUS, d);            // reads leave the count running
            n++;
        end
        if (!d[23]) begin
            $display("timeout at %0t: watchdog never fired", $time);
            report_failure();
        end
        m_timeout = 1'b1;
        m_enabled = '0;
        idle(1);
        check_axes(amp_disable, '1, "amp_disable after watchdog");
        check_status("status after watchdog");
        write_reg(main_addr(REG_TIMEOUT), 32'd0);   // stop the watchdog
        status_write(PWR_ON);
        check_status("timeout cleared by power-up");
    endtask

    task automatic test_safety_delay();
        int k;
        int held;
        status_write(axis_word('1, '1));
        wait_amp_disable('0, "amps on");
        k = int'(random_bits(2));
        safety_amp_disable = axis_vec_t'(1 << k);
        idle(1);
        safety_amp_disable = '0;
        m_enabled[k] = 1'b0;
        idle(2);
        check_axes(amp_disable, ~m_enabled, "safety disables one axis");
        mv_good = 1'b0;
        idle(1);
        check_axes(amp_disable, '1, "amp_disable with mv_good low");
        check_status("status with mv_good low");
        mv_good = 1'b1;
        held = 0;
        while (amp_disable === '1 && held < WAIT_LIMIT) begin
            idle(1);
            held++;
        end
        if (amp_disable === '1) begin
            $display("timeout at %0t: amp hold never released", $time);
            report_failure();
        end
        check_axes(amp_disable, ~m_enabled, "amp_disable after hold");
        if (held < (MV_DELAY_TICKS - 1) * TICK_PERIOD) begin
            $display("Fail at %0t: amp hold released after only %0d cycles", $time, held);
            report_failure();
        end
    endtask

    initial begin
        lfsr_state = 16'd71;
        rst_n = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        {dout, enc_a, enc_b, enc_i, neg_limit, pos_limit, home, fault} = '0;
        safety_amp_disable = '0;
        {dout_cfg_valid, dout_cfg_bidir, relay, v_fault, io1_8} = '0;
        mv_faultn = 1'b1;
        mv_good = 1'b1;
        board_id = '0;
        temp_sense = '0;
        {m_pwr, m_relay_on, m_eth, m_timeout} = '0;
        m_enabled = '0;
        idle(2);
        rst_n = 1'b1;
        test_reset_values();
        test_masked_writes();
        test_read_words();
        test_watchdog();
        test_safety_delay();
        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule
